//--- motorStep_defs.svh
`ifndef MOTORSTEP_DEFS_SVH
`define MOTORSTEP_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Step period limits, in clk cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define STEP_PERIOD_INIT    25'd40
`define STEP_PERIOD_MIN     25'd12      // Must exceed DEAD_CYCLES + 2
`define STEP_PERIOD_MAX     25'd80
`define STEP_PERIOD_DELTA   25'd4       // Change per freqInc/freqDec strobe

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Driver and buffer sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DEAD_CYCLES         4           // All-off gap between patterns
`define STEP_FIFO_DEPTH     4
`define ROUND_COUNT_WIDTH   16

`endif

//--- motorStepPkg.sv
`include "motorStep_defs.svh"

package motorStepPkg;

    typedef logic [3:0]                      stepIndex_t;   // 1 to 12 valid
    typedef logic [24:0]                     stepPeriod_t;
    typedef logic [`ROUND_COUNT_WIDTH-1:0]   roundCount_t;

    // One commutation step, all three phases
    typedef struct packed {
        stepIndex_t  stepA;
        stepIndex_t  stepB;
        stepIndex_t  stepC;
        roundCount_t round;
    } stepEvent_t;

    // Bit 0 is phase A
    typedef struct packed {
        logic [2:0] highSide;
        logic [2:0] lowSide;
    } gateDrive_t;

    typedef enum logic [1:0] {
        idle,
        deadTime,
        apply
    } driverState_t;

endpackage

//--- stepGenerator.sv
`timescale 1ns/10ps
`include "motorStep_defs.svh"

module stepGenerator import motorStepPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        freqInc,
    input  logic        freqDec,
    output logic        stepStrobe,
    output stepEvent_t  stepEvent,
    output stepPeriod_t stepPeriod
);

    logic        startDly;
    logic        startRise;
    logic        countLast;
    stepPeriod_t countDown;
    stepIndex_t  stepA;
    stepIndex_t  stepB;
    stepIndex_t  stepC;
    roundCount_t roundCnt;

    assign startRise = start && !startDly;
    assign countLast = (countDown == stepPeriod_t'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            startDly <= 1'b0;
        end else begin
            startDly <= start;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Period register and countdown
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset || startRise) begin
            stepPeriod <= `STEP_PERIOD_INIT;
        end else if (freqInc && !freqDec) begin
            if (stepPeriod < `STEP_PERIOD_MIN + `STEP_PERIOD_DELTA) begin
                stepPeriod <= `STEP_PERIOD_MIN;     // Clamp at fastest
            end else begin
                stepPeriod <= stepPeriod - `STEP_PERIOD_DELTA;
            end
        end else if (freqDec && !freqInc) begin
            if (stepPeriod > `STEP_PERIOD_MAX - `STEP_PERIOD_DELTA) begin
                stepPeriod <= `STEP_PERIOD_MAX;     // Clamp at slowest
            end else begin
                stepPeriod <= stepPeriod + `STEP_PERIOD_DELTA;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !start) begin
            countDown <= '0;
        end else if (startRise) begin
            countDown <= `STEP_PERIOD_INIT;
        end else if (countLast) begin
            countDown <= stepPeriod;                // New period applies here
        end else begin
            countDown <= countDown - 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 12-step sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset || !start) begin
            stepStrobe <= 1'b0;
            stepA      <= '0;
            roundCnt   <= '0;
        end else begin
            stepStrobe <= startRise || countLast;
            if (startRise) begin
                stepA    <= 4'd1;
                roundCnt <= '0;
            end else if (countLast) begin
                if (stepA == 4'd12) begin
                    stepA    <= 4'd1;
                    roundCnt <= roundCnt + 1'b1;    // Round done
                end else begin
                    stepA <= stepA + 4'd1;
                end
            end
        end
    end

    // B leads A by 8 steps, C leads A by 4
    always_comb begin
        if (stepA == 4'd0 || stepA > 4'd12) begin
            stepB = 4'hF;
            stepC = 4'hF;
        end else begin
            stepB = (stepA > 4'd4) ? stepA - 4'd4 : stepA + 4'd8;
            stepC = (stepA > 4'd8) ? stepA - 4'd8 : stepA + 4'd4;
        end
    end

    assign stepEvent = '{stepA: stepA, stepB: stepB, stepC: stepC, round: roundCnt};

endmodule

//--- stepFifo.sv
`timescale 1ns/10ps
`include "motorStep_defs.svh"

module stepFifo import motorStepPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  logic       push,
    input  stepEvent_t pushEvent,
    input  logic       pop,
    output stepEvent_t popEvent,
    output logic       notEmpty,
    output logic       overflow
);

    localparam int depth    = `STEP_FIFO_DEPTH;
    localparam int ptrWidth = $clog2(depth);
    localparam int cntWidth = $clog2(depth + 1);

    stepEvent_t          mem [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] fillCount;
    logic                full;
    logic                doPush;
    logic                doPop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (fillCount == cntWidth'(depth));
    assign notEmpty = (fillCount != '0);
    assign doPush   = run && push && !full;     // Full drops the event
    assign doPop    = run && pop && notEmpty;
    assign popEvent = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushEvent;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers, fill level, overflow
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
            overflow  <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
            if (push && full) begin
                overflow <= 1'b1;               // Sticky until run drops
            end
        end
    end

endmodule

//--- phaseDriver.sv
`timescale 1ns/10ps
`include "motorStep_defs.svh"

module phaseDriver import motorStepPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        notEmpty,
    input  stepEvent_t  popEvent,
    output logic        pop,
    output gateDrive_t  gates,
    output roundCount_t appliedRound
);

    localparam int deadWidth = $clog2(`DEAD_CYCLES + 1);

    driverState_t         state;
    logic [deadWidth-1:0] deadCount;
    stepEvent_t           latched;
    logic [1:0]           driveA;
    logic [1:0]           driveB;
    logic [1:0]           driveC;

    // Returns {high, low} for one phase
    function automatic logic [1:0] phaseDrive(input stepIndex_t idx);
        logic [1:0] drive;
        drive = 2'b00;                          // Float
        if (idx >= 4'd1 && idx <= 4'd4) begin
            drive = 2'b10;
        end else if (idx >= 4'd7 && idx <= 4'd10) begin
            drive = 2'b01;
        end
        return drive;
    endfunction

    // Accept a new step outside the dead time
    assign pop = run && notEmpty && (state != deadTime);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Dead-time FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            state     <= idle;
            deadCount <= '0;
        end else begin
            case (state)
                idle, apply: begin
                    if (pop) begin
                        state     <= deadTime;
                        deadCount <= deadWidth'(`DEAD_CYCLES - 1);
                    end
                end
                deadTime: begin
                    if (deadCount == '0) begin
                        state <= apply;
                    end else begin
                        deadCount <= deadCount - 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            latched <= '0;
        end else if (pop) begin
            latched <= popEvent;
        end
    end

    assign driveA = phaseDrive(latched.stepA);
    assign driveB = phaseDrive(latched.stepB);
    assign driveC = phaseDrive(latched.stepC);

    always_comb begin
        gates = '0;                             // All off unless applying
        if (state == apply) begin
            gates.highSide = {driveC[1], driveB[1], driveA[1]};
            gates.lowSide  = {driveC[0], driveB[0], driveA[0]};
        end
    end

    assign appliedRound = latched.round;

endmodule

//--- motorStepTop.sv
`timescale 1ns/10ps

module motorStepTop import motorStepPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        freqInc,
    input  logic        freqDec,
    output gateDrive_t  gates,
    output stepPeriod_t stepPeriod,
    output roundCount_t roundCount,
    output logic        overflow
);

    logic       stepStrobe;
    stepEvent_t stepEvent;
    stepEvent_t headEvent;
    logic       notEmpty;
    logic       pop;

    stepGenerator stepGenerator_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .freqInc    (freqInc),
        .freqDec    (freqDec),
        .stepStrobe (stepStrobe),
        .stepEvent  (stepEvent),
        .stepPeriod (stepPeriod)
    );

    stepFifo stepFifo_inst (
        .clk       (clk),
        .reset     (reset),
        .run       (start),                     // Stop flushes pending steps
        .push      (stepStrobe),
        .pushEvent (stepEvent),
        .pop       (pop),
        .popEvent  (headEvent),
        .notEmpty  (notEmpty),
        .overflow  (overflow)
    );

    phaseDriver phaseDriver_inst (
        .clk          (clk),
        .reset        (reset),
        .run          (start),
        .notEmpty     (notEmpty),
        .popEvent     (headEvent),
        .pop          (pop),
        .gates        (gates),
        .appliedRound (roundCount)
    );

endmodule

//--- motorStepChecker.sv
`timescale 1ns/10ps
`include "motorStep_defs.svh"

module motorStepChecker import motorStepPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        freqInc,
    input  logic        freqDec,
    input  gateDrive_t  gates,
    input  stepPeriod_t stepPeriod,
    input  roundCount_t roundCount,
    input  logic        overflow,
    output int          errorCount,
    output int          patternCount,
    output int          intervalCount
);

    int         expPeriod;
    int         expStep;                        // 0 until the first pattern of a run
    int         expRound;
    int         runPatterns;
    int         offRun;
    int         stopRun;
    int         cycle;
    int         lastChange;
    int         prevChange;
    int         periodChangedAt;
    logic       startDly;
    logic       resetDly;
    gateDrive_t lastGates;
    gateDrive_t expGates;

    // Expected gates for a phase A step index
    function automatic gateDrive_t refPattern(input int stepA);
        gateDrive_t drive;
        int         idx [3];
        int         p;
        drive  = '0;
        idx[0] = stepA;
        idx[1] = (stepA + 7) % 12 + 1;          // A + 8
        idx[2] = (stepA + 3) % 12 + 1;          // A + 4
        for (p = 0; p < 3; p++) begin
            drive.highSide[p] = (idx[p] >= 1) && (idx[p] <= 4);
            drive.lowSide[p]  = (idx[p] >= 7) && (idx[p] <= 10);
        end
        return drive;
    endfunction

    task automatic wrongValue(input string name, input int expected, input int actual);
        $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic failure(input string what);
        $display("error at %0t: %s", $time, what);
        errorCount++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic newPattern();
        if (expStep == 0) begin
            expStep     = 1;                    // Run starts at step 1
            expRound    = 0;
            runPatterns = 0;
        end else begin
            if (lastGates != '0) begin
                failure("gates switched to a new pattern without any dead time");
            end else if (offRun != `DEAD_CYCLES) begin
                wrongValue("dead time", `DEAD_CYCLES, offRun);
            end
            expStep = expStep % 12 + 1;
            if (expStep == 1) begin
                expRound++;
            end
        end
        // Only once the period was stable across the reload
        if (runPatterns >= 2 && periodChangedAt < prevChange) begin
            intervalCount++;
            if (cycle - lastChange != expPeriod) begin
                wrongValue("step interval", expPeriod, cycle - lastChange);
            end
        end
        expGates = refPattern(expStep);
        if (gates !== expGates) begin
            wrongValue("gates", expGates, gates);
        end
        if ($countones(gates.highSide) != 1 || $countones(gates.lowSide) != 1) begin
            failure("pattern does not drive exactly one phase high and one low");
        end
        if (roundCount !== roundCount_t'(expRound)) begin
            wrongValue("roundCount", expRound, roundCount);
        end
        prevChange = lastChange;
        lastChange = cycle;
        runPatterns++;
        patternCount++;
    endtask

    task automatic trackGates();
        if (!start) begin
            if (stopRun >= 2 && gates != '0) begin
                failure("gates still on two cycles after start dropped");
            end
            stopRun++;
            expStep = 0;
        end else begin
            stopRun = 0;
            if (gates == '0) begin
                offRun++;
            end else if (gates != lastGates) begin
                newPattern();
                offRun = 0;
            end
        end
    endtask

    task automatic updatePeriod();
        int newPeriod;
        newPeriod = expPeriod;
        if (start && !startDly) begin
            newPeriod = `STEP_PERIOD_INIT;
        end else if (freqInc && !freqDec) begin
            newPeriod = expPeriod - `STEP_PERIOD_DELTA;     // Faster
            if (newPeriod < `STEP_PERIOD_MIN) begin
                newPeriod = `STEP_PERIOD_MIN;
            end
        end else if (freqDec && !freqInc) begin
            newPeriod = expPeriod + `STEP_PERIOD_DELTA;
            if (newPeriod > `STEP_PERIOD_MAX) begin
                newPeriod = `STEP_PERIOD_MAX;
            end
        end
        if (newPeriod != expPeriod) begin
            periodChangedAt = cycle;
        end
        expPeriod = newPeriod;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sampling at each rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        errorCount    = 0;
        patternCount  = 0;
        intervalCount = 0;
        cycle         = 0;
        resetDly      = 1'b0;
        forever begin
            @(posedge clk);
            cycle++;
            if (reset) begin
                expPeriod       = `STEP_PERIOD_INIT;
                periodChangedAt = cycle;
                startDly        = 1'b0;
                expStep         = 0;
                stopRun         = 0;
                offRun          = 0;
            end else begin
                if (resetDly) begin                 // First cycle out of reset
                    if (gates !== '0) begin
                        wrongValue("gates", 0, gates);
                    end
                    if (roundCount !== '0) begin
                        wrongValue("roundCount", 0, roundCount);
                    end
                end
                if (stepPeriod !== stepPeriod_t'(expPeriod)) begin
                    wrongValue("stepPeriod", expPeriod, stepPeriod);
                end
                if (overflow !== 1'b0) begin
                    wrongValue("overflow", 0, overflow);
                end
                trackGates();
                updatePeriod();
                startDly = start;
            end
            lastGates = gates;
            resetDly  = reset;
        end
    end

endmodule

//--- motorStepTb.sv
`timescale 1ns/10ps
`include "motorStep_defs.svh"

module motorStepTb import motorStepPkg::*; ();

    logic        clk;
    logic        reset;
    logic        start;
    logic        freqInc;
    logic        freqDec;
    gateDrive_t  gates;
    stepPeriod_t stepPeriod;
    roundCount_t roundCount;
    logic        overflow;
    int          errorCount;
    int          patternCount;
    int          intervalCount;
    int          runSteps [3];
    int          testNum;
    int          testErrors;
    longint      watchLimit;

    motorStepTop motorStepTop_inst (.*);

    motorStepChecker motorStepChecker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        wait (watchLimit > 0);
        #(watchLimit);
        $display("error: watchdog expired at %0t, the DUT stopped producing steps", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic finishTest(input string name);
        @(negedge clk);
        $display("test %0d %s: %0d errors", testNum, name, errorCount - testErrors);
        testErrors = errorCount;
        testNum++;
    endtask

    task automatic waitSteps(input int count);
        int target;
        target = patternCount + count;
        wait (patternCount >= target);
        @(posedge clk);
    endtask

    task automatic pulseFreq(input logic faster, input int count);
        int gap;
        repeat (count) begin
            gap = $urandom_range(30, 1);
            repeat (gap) @(posedge clk);
            if (faster) begin
                freqInc <= 1'b1;
            end else begin
                freqDec <= 1'b1;
            end
            @(posedge clk);
            freqInc <= 1'b0;
            freqDec <= 1'b0;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'h9bad_cf4d));
        reset      = 1'b1;
        start      = 1'b0;
        freqInc    = 1'b0;
        freqDec    = 1'b0;
        testNum    = 1;
        testErrors = 0;
        foreach (runSteps[i]) begin
            runSteps[i] = $urandom_range(30, 14);       // Spans past one round
        end
        // Every step at the slowest period, plus slack for the strobe phase
        watchLimit = (runSteps.sum() + 60) * `STEP_PERIOD_MAX * 2 * 20;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        finishTest("reset");

        @(posedge clk);
        start <= 1'b1;
        waitSteps(runSteps[0]);
        finishTest("step sequence and dead time");

        @(posedge clk);
        start <= 1'b0;
        repeat (4) @(posedge clk);
        start <= 1'b1;
        waitSteps(runSteps[1]);
        finishTest("round count after restart");

        @(posedge clk);
        pulseFreq(1'b1, $urandom_range(12, 8));         // Runs into the minimum
        waitSteps(4);
        pulseFreq(1'b0, $urandom_range(24, 19));        // Runs into the maximum
        waitSteps(runSteps[2]);
        finishTest("frequency strobes");

        @(posedge clk);
        start <= 1'b0;
        repeat (4) @(posedge clk);
        finishTest("stop");

        $display("%0d tests, %0d patterns, %0d intervals, %0d errors",
                 testNum - 1, patternCount, intervalCount, errorCount);
        if (intervalCount == 0) begin
            $display("error: no step interval could be measured");
        end
        if (errorCount == 0 && intervalCount > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- motorStep.f
+incdir+.
motorStepPkg.sv
stepGenerator.sv
stepFifo.sv
phaseDriver.sv
motorStepTop.sv
motorStepChecker.sv
motorStepTb.sv

//--- Bender.yml
package:
  name: motorStep

sources:
  - include_dirs:
      - .
    files:
      - motorStepPkg.sv
      - stepGenerator.sv
      - stepFifo.sv
      - phaseDriver.sv
      - motorStepTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - motorStepChecker.sv
      - motorStepTb.sv
